/* design/cp0_regs.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cp0_regs (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  cpu_types_pkg::cp0_addr_t   wb_adr,
	input  cpu_types_pkg::word_t       wb_dat_i,
	input  logic [3:0]                 wb_sel,
	output cpu_types_pkg::word_t       wb_dat_o,
	output logic                       wb_ack,
	input  logic                       wbk_cp0_we,
	input  cpu_types_pkg::cp0_addr_t   wbk_cp0_addr,
	input  cpu_types_pkg::word_t       wbk_cp0_wdata,
	input  except_pkg::cp0_wmask_t     wbk_mask,
	input  logic [`HW_INT_W-1:0]       hw_int,
	input  logic                       exc_flush,
	input  logic                       exc_eret,
	input  cpu_types_pkg::exc_code_t   exc_code,
	input  cpu_types_pkg::inst_addr_t  exc_cur_pc,
	input  logic                       exc_delayslot,
	output cpu_types_pkg::word_t       status,
	output cpu_types_pkg::word_t       cause,
	output cpu_types_pkg::word_t       epc,
	output cpu_types_pkg::word_t       error_epc
);

	except_pkg::wb_state_t  wb_state;
	except_pkg::wb_state_t  wb_state_nxt;
	except_pkg::cp0_wmask_t wb_mask;
	except_pkg::cp0_wmask_t wb_sel_mask;
	cpu_types_pkg::word_t   status_nxt;
	cpu_types_pkg::word_t   cause_nxt;
	cpu_types_pkg::word_t   epc_nxt;
	cpu_types_pkg::word_t   error_epc_nxt;
	logic                   busy;
	logic                   wb_go;
	logic                   wb_wr;

	cp0_write_mask wb_write_mask_inst (
		.addr(wb_adr),
		.mask(wb_mask)
	);

	function automatic cpu_types_pkg::word_t merge(
		input cpu_types_pkg::word_t old,
		input cpu_types_pkg::word_t wdata,
		input cpu_types_pkg::word_t mask
	);
		return (old & ~mask) | (wdata & mask);
	endfunction

	// Bus access holds off while the pipeline owns CP0
	assign busy        = exc_flush | wbk_cp0_we;
	assign wb_go       = wb_cyc & wb_stb & ~busy & (wb_state != except_pkg::WB_ACK);
	assign wb_wr       = wb_go & wb_we;
	assign wb_sel_mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
	assign wb_ack      = (wb_state == except_pkg::WB_ACK);

	always_comb begin
		wb_state_nxt = wb_state;
		case (wb_state)
			except_pkg::WB_IDLE: begin
				if (wb_cyc && wb_stb)
					wb_state_nxt = busy ? except_pkg::WB_WAIT : except_pkg::WB_ACK;
			end
			except_pkg::WB_WAIT: begin
				if (!wb_cyc)
					wb_state_nxt = except_pkg::WB_IDLE;
				else if (!busy)
					wb_state_nxt = except_pkg::WB_ACK;
			end
			default: begin
				wb_state_nxt = except_pkg::WB_IDLE;
			end
		endcase
	end

	always_comb begin
		case (wb_adr)
			`CP0_STATUS:    wb_dat_o = status;
			`CP0_CAUSE:     wb_dat_o = cause;
			`CP0_EPC:       wb_dat_o = epc;
			`CP0_ERROR_EPC: wb_dat_o = error_epc;
			default:        wb_dat_o = '0;
		endcase
	end

	// Writes layered from lowest to highest priority
	always_comb begin
		status_nxt    = status;
		cause_nxt     = cause;
		epc_nxt       = epc;
		error_epc_nxt = error_epc;
		if (wb_wr) begin
			case (wb_adr)
				`CP0_STATUS:    status_nxt = merge(status, wb_dat_i, wb_mask & wb_sel_mask);
				`CP0_CAUSE:     cause_nxt = merge(cause, wb_dat_i, wb_mask & wb_sel_mask);
				`CP0_EPC:       epc_nxt = merge(epc, wb_dat_i, wb_mask & wb_sel_mask);
				`CP0_ERROR_EPC: error_epc_nxt = merge(error_epc, wb_dat_i, wb_mask & wb_sel_mask);
				default: ;
			endcase
		end
		if (wbk_cp0_we) begin
			case (wbk_cp0_addr)
				`CP0_STATUS:    status_nxt = merge(status_nxt, wbk_cp0_wdata, wbk_mask);
				`CP0_CAUSE:     cause_nxt = merge(cause_nxt, wbk_cp0_wdata, wbk_mask);
				`CP0_EPC:       epc_nxt = merge(epc_nxt, wbk_cp0_wdata, wbk_mask);
				`CP0_ERROR_EPC: error_epc_nxt = merge(error_epc_nxt, wbk_cp0_wdata, wbk_mask);
				default: ;
			endcase
		end
		if (exc_flush) begin
			if (exc_eret) begin
				if (status_nxt[`ST_ERL])
					status_nxt[`ST_ERL] = 1'b0;
				else
					status_nxt[`ST_EXL] = 1'b0;
			end else begin
				// Nested exceptions keep the first EPC and BD
				if (!status_nxt[`ST_EXL]) begin
					epc_nxt = exc_delayslot ? exc_cur_pc - 32'd4 : exc_cur_pc;
					cause_nxt[`CA_BD] = exc_delayslot;
				end
				cause_nxt[`CA_EXCCODE] = exc_code;
				status_nxt[`ST_EXL]    = 1'b1;
			end
		end
		cause_nxt[`CA_IP_HW] = hw_int;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_state  <= except_pkg::WB_IDLE;
			status    <= `STATUS_RST;
			cause     <= '0;
			epc       <= '0;
			error_epc <= '0;
		end else begin
			wb_state  <= wb_state_nxt;
			status    <= status_nxt;
			cause     <= cause_nxt;
			epc       <= epc_nxt;
			error_epc <= error_epc_nxt;
		end
	end

	wb_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack);

	// Master keeps the cycle open until it sees ack
	wb_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

/* design/cp0_write_mask.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cp0_write_mask (
	input  cpu_types_pkg::cp0_addr_t addr,
	output except_pkg::cp0_wmask_t   mask
);

	always_comb begin
		mask = '0;
		case (addr)
			`CP0_STATUS: begin
				mask[`ST_IM]  = '1;
				mask[`ST_IE]  = 1'b1;
				mask[`ST_EXL] = 1'b1;
				mask[`ST_ERL] = 1'b1;
				mask[`ST_BEV] = 1'b1;
			end
			`CP0_CAUSE: begin
				// Only the software interrupt bits and IV
				mask[`CA_IP_SW] = '1;
				mask[`CA_IV]    = 1'b1;
			end
			`CP0_EPC: begin
				mask = '1;
			end
			`CP0_ERROR_EPC: begin
				mask = '1;
			end
			default: begin
				mask = '0;
			end
		endcase
	end

endmodule

/* design/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define WORD_W      32
`define CP0_ADDR_W  5
`define HW_INT_W    6

// CP0 register numbers
`define CP0_STATUS     5'd12
`define CP0_CAUSE      5'd13
`define CP0_EPC        5'd14
`define CP0_ERROR_EPC  5'd30

// Status and Cause field positions
`define ST_IE       0
`define ST_EXL      1
`define ST_ERL      2
`define ST_IM       15:8
`define ST_BEV      22
`define CA_EXCCODE  6:2
`define CA_IP       15:8
`define CA_IP_SW    9:8
`define CA_IP_HW    15:10
`define CA_IV       23
`define CA_BD       31

// BEV and ERL set, everything else clear
`define STATUS_RST  32'h0040_0004

`define EXCCODE_INT   5'd0
`define EXCCODE_MOD   5'd1
`define EXCCODE_TLBL  5'd2
`define EXCCODE_TLBS  5'd3
`define EXCCODE_ADEL  5'd4
`define EXCCODE_ADES  5'd5
`define EXCCODE_SYS   5'd8
`define EXCCODE_BP    5'd9
`define EXCCODE_RI    5'd10
`define EXCCODE_CPU   5'd11
`define EXCCODE_OV    5'd12
`define EXCCODE_TR    5'd13

`define VEC_BASE_BEV   32'hbfc0_0200
`define VEC_BASE_NORM  32'h8000_0000
`define VEC_OFS_TLB    32'h0000_0000
`define VEC_OFS_GEN    32'h0000_0180
`define VEC_OFS_IV     32'h0000_0200

// Exception flag bit indices
`define EXC_IADDR_ILLEGAL    0
`define EXC_IADDR_MISS       1
`define EXC_IADDR_INVALID    2
`define EXC_SYSCALL          3
`define EXC_BREAK            4
`define EXC_OVERFLOW         5
`define EXC_TRAP             6
`define EXC_ERET             7
`define EXC_PRIV_INST        8
`define EXC_INVALID_INST     9
`define EXC_DADDR_UNALIGNED  10
`define EXC_DADDR_ILLEGAL    11
`define EXC_DADDR_MISS       12
`define EXC_DADDR_INVALID    13
`define EXC_DADDR_READONLY   14
`define EXC_FLAGS_W          15

`endif

/* design/cpu_types_pkg.sv */
`include "cpu_cfg.svh"

package cpu_types_pkg;

	// One machine word
	typedef logic [`WORD_W-1:0] word_t;

	// Program counter
	typedef logic [`WORD_W-1:0] inst_addr_t;

	// CP0 register number
	typedef logic [`CP0_ADDR_W-1:0] cp0_addr_t;

	// Cause.ExcCode
	typedef logic [4:0] exc_code_t;

endpackage

/* design/except.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module except (
	input  cpu_types_pkg::word_t       status,
	input  cpu_types_pkg::word_t       cause,
	input  cpu_types_pkg::word_t       epc,
	input  cpu_types_pkg::word_t       error_epc,
	input  logic                       wbk_cp0_we,
	input  cpu_types_pkg::cp0_addr_t   wbk_cp0_addr,
	input  cpu_types_pkg::word_t       wbk_cp0_wdata,
	input  except_pkg::cp0_wmask_t     wbk_mask,
	input  cpu_types_pkg::inst_addr_t  pc_a,
	input  cpu_types_pkg::inst_addr_t  pc_b,
	input  logic                       ds_a,
	input  logic                       ds_b,
	input  except_pkg::except_flags_t  flags_a,
	input  except_pkg::except_flags_t  flags_b,
	input  logic                       is_user_mode,
	input  logic                       mem_we,
	output logic                       exc_flush,
	output logic                       exc_alpha_taken,
	output cpu_types_pkg::exc_code_t   exc_code,
	output logic                       exc_eret,
	output logic                       exc_delayslot,
	output cpu_types_pkg::inst_addr_t  exc_cur_pc,
	output cpu_types_pkg::inst_addr_t  exc_jump_pc
);

	cpu_types_pkg::word_t      st;
	cpu_types_pkg::word_t      ca;
	cpu_types_pkg::word_t      ep;
	cpu_types_pkg::word_t      ee;
	except_pkg::except_flags_t flags;
	logic                      int_occur;
	logic                      exc_occur;
	logic                      alpha;
	logic                      is_eret;
	cpu_types_pkg::exc_code_t  code;
	cpu_types_pkg::inst_addr_t offset;
	cpu_types_pkg::inst_addr_t base;

	// An mtc0 in writeback is visible to the instruction committing now
	always_comb begin
		st = status;
		ca = cause;
		ep = epc;
		ee = error_epc;
		if (wbk_cp0_we) begin
			case (wbk_cp0_addr)
				`CP0_STATUS:    st = (st & ~wbk_mask) | (wbk_cp0_wdata & wbk_mask);
				`CP0_CAUSE:     ca = (ca & ~wbk_mask) | (wbk_cp0_wdata & wbk_mask);
				`CP0_EPC:       ep = (ep & ~wbk_mask) | (wbk_cp0_wdata & wbk_mask);
				`CP0_ERROR_EPC: ee = (ee & ~wbk_mask) | (wbk_cp0_wdata & wbk_mask);
				default: ;
			endcase
		end
	end

	always_comb begin
		flags = flags_a | flags_b;
		flags[`EXC_PRIV_INST] = flags[`EXC_PRIV_INST] & is_user_mode;
	end

	assign int_occur = st[`ST_IE] && !st[`ST_EXL] && !st[`ST_ERL] &&
		((ca[`CA_IP] & st[`ST_IM]) != 8'b0);
	assign exc_occur = int_occur || (|flags);

	// MIPS32 priority order, interrupts first
	always_comb begin
		code    = '0;
		alpha   = 1'b0;
		is_eret = 1'b0;
		if (int_occur) begin
			code  = `EXCCODE_INT;
			alpha = 1'b1;
		end else if (flags[`EXC_IADDR_ILLEGAL]) begin
			code  = `EXCCODE_ADEL;
			alpha = flags_a[`EXC_IADDR_ILLEGAL];
		end else if (flags[`EXC_IADDR_MISS]) begin
			code  = `EXCCODE_TLBL;
			alpha = flags_a[`EXC_IADDR_MISS];
		end else if (flags[`EXC_IADDR_INVALID]) begin
			code  = `EXCCODE_TLBL;
			alpha = flags_a[`EXC_IADDR_INVALID];
		end else if (flags[`EXC_SYSCALL]) begin
			code  = `EXCCODE_SYS;
			alpha = flags_a[`EXC_SYSCALL];
		end else if (flags[`EXC_BREAK]) begin
			code  = `EXCCODE_BP;
			alpha = flags_a[`EXC_BREAK];
		end else if (flags[`EXC_OVERFLOW]) begin
			code  = `EXCCODE_OV;
			alpha = flags_a[`EXC_OVERFLOW];
		end else if (flags[`EXC_TRAP]) begin
			code  = `EXCCODE_TR;
			alpha = flags_a[`EXC_TRAP];
		end else if (flags[`EXC_ERET]) begin
			// eret only issues on pipe a
			alpha   = flags_a[`EXC_ERET];
			is_eret = flags_a[`EXC_ERET];
		end else if (flags[`EXC_PRIV_INST]) begin
			code  = `EXCCODE_CPU;
			alpha = flags_a[`EXC_PRIV_INST];
		end else if (flags[`EXC_INVALID_INST]) begin
			code  = `EXCCODE_RI;
			alpha = flags_a[`EXC_INVALID_INST];
		end else if (flags[`EXC_DADDR_UNALIGNED] || flags[`EXC_DADDR_ILLEGAL]) begin
			code  = mem_we ? `EXCCODE_ADES : `EXCCODE_ADEL;
			alpha = flags_a[`EXC_DADDR_UNALIGNED] | flags_a[`EXC_DADDR_ILLEGAL];
		end else if (flags[`EXC_DADDR_MISS]) begin
			code  = mem_we ? `EXCCODE_TLBS : `EXCCODE_TLBL;
			alpha = flags_a[`EXC_DADDR_MISS];
		end else if (flags[`EXC_DADDR_INVALID]) begin
			code  = mem_we ? `EXCCODE_TLBS : `EXCCODE_TLBL;
			alpha = flags_a[`EXC_DADDR_INVALID];
		end else if (flags[`EXC_DADDR_READONLY]) begin
			code  = `EXCCODE_MOD;
			alpha = flags_a[`EXC_DADDR_READONLY];
		end
	end

	always_comb begin
		if (!st[`ST_EXL] && (code == `EXCCODE_TLBL || code == `EXCCODE_TLBS))
			offset = `VEC_OFS_TLB;
		else if (!st[`ST_EXL] && int_occur && ca[`CA_IV])
			offset = `VEC_OFS_IV;
		else
			offset = `VEC_OFS_GEN;
		base = st[`ST_BEV] ? `VEC_BASE_BEV : `VEC_BASE_NORM;
	end

	assign exc_alpha_taken = alpha;

	always_comb begin
		exc_flush     = 1'b0;
		exc_code      = '0;
		exc_eret      = 1'b0;
		exc_delayslot = 1'b0;
		exc_cur_pc    = '0;
		exc_jump_pc   = '0;
		if (exc_occur) begin
			exc_flush     = 1'b1;
			exc_code      = code;
			exc_eret      = is_eret;
			exc_delayslot = alpha ? ds_a : ds_b;
			exc_cur_pc    = alpha ? pc_a : pc_b;
			if (is_eret)
				exc_jump_pc = st[`ST_ERL] ? ee : ep;
			else
				exc_jump_pc = base + offset;
		end
	end

	// The decoder upstream never routes eret to the second pipe
	eret_pipe_a_only: assert final (!flags_b[`EXC_ERET])
		else $error("eret flag seen on pipe b");

endmodule

/* design/except_pkg.sv */
`include "cpu_cfg.svh"

package except_pkg;

	// Per-pipe exception flags, indexed by the EXC_* bits
	typedef logic [`EXC_FLAGS_W-1:0] except_flags_t;

	// Software-writable bits of one CP0 register
	typedef cpu_types_pkg::word_t cp0_wmask_t;

	// Wishbone slave state
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_WAIT,
		WB_ACK
	} wb_state_t;

endpackage

/* design/except_subsys.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module except_subsys (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  cpu_types_pkg::cp0_addr_t   wb_adr,
	input  cpu_types_pkg::word_t       wb_dat_i,
	input  logic [3:0]                 wb_sel,
	output cpu_types_pkg::word_t       wb_dat_o,
	output logic                       wb_ack,
	input  logic                       wbk_cp0_we,
	input  cpu_types_pkg::cp0_addr_t   wbk_cp0_addr,
	input  cpu_types_pkg::word_t       wbk_cp0_wdata,
	input  logic [`HW_INT_W-1:0]       hw_int,
	input  cpu_types_pkg::inst_addr_t  pc_a,
	input  cpu_types_pkg::inst_addr_t  pc_b,
	input  logic                       ds_a,
	input  logic                       ds_b,
	input  except_pkg::except_flags_t  flags_a,
	input  except_pkg::except_flags_t  flags_b,
	input  logic                       is_user_mode,
	input  logic                       mem_we,
	output logic                       exc_flush,
	output logic                       exc_alpha_taken,
	output cpu_types_pkg::exc_code_t   exc_code,
	output logic                       exc_eret,
	output logic                       exc_delayslot,
	output cpu_types_pkg::inst_addr_t  exc_cur_pc,
	output cpu_types_pkg::inst_addr_t  exc_jump_pc
);

	except_pkg::cp0_wmask_t wbk_mask;
	cpu_types_pkg::word_t   status;
	cpu_types_pkg::word_t   cause;
	cpu_types_pkg::word_t   epc;
	cpu_types_pkg::word_t   error_epc;

	// Shared by the register block and the resolver bypass
	cp0_write_mask wbk_write_mask_inst (
		.addr(wbk_cp0_addr),
		.mask(wbk_mask)
	);

	cp0_regs cp0_regs_inst (
		.clk,
		.arst_n,
		.wb_cyc,
		.wb_stb,
		.wb_we,
		.wb_adr,
		.wb_dat_i,
		.wb_sel,
		.wb_dat_o,
		.wb_ack,
		.wbk_cp0_we,
		.wbk_cp0_addr,
		.wbk_cp0_wdata,
		.wbk_mask,
		.hw_int,
		.exc_flush,
		.exc_eret,
		.exc_code,
		.exc_cur_pc,
		.exc_delayslot,
		.status,
		.cause,
		.epc,
		.error_epc
	);

	except except_inst (
		.status,
		.cause,
		.epc,
		.error_epc,
		.wbk_cp0_we,
		.wbk_cp0_addr,
		.wbk_cp0_wdata,
		.wbk_mask,
		.pc_a,
		.pc_b,
		.ds_a,
		.ds_b,
		.flags_a,
		.flags_b,
		.is_user_mode,
		.mem_we,
		.exc_flush,
		.exc_alpha_taken,
		.exc_code,
		.exc_eret,
		.exc_delayslot,
		.exc_cur_pc,
		.exc_jump_pc
	);

endmodule

/* files.f */
+incdir+design
+incdir+testbench
design/cpu_types_pkg.sv
design/except_pkg.sv
design/cp0_write_mask.sv
design/cp0_regs.sv
design/except.sv
design/except_subsys.sv
testbench/except_tb.sv

/* testbench/except_model.svh */
`ifndef EXCEPT_MODEL_SVH
`define EXCEPT_MODEL_SVH

// Software-writable bits per CP0 register
function automatic logic [31:0] mask_of(input logic [4:0] addr);
	case (addr)
		`CP0_STATUS:    return 32'h0040_ff07;
		`CP0_CAUSE:     return 32'h0080_0300;
		`CP0_EPC:       return 32'hffff_ffff;
		`CP0_ERROR_EPC: return 32'hffff_ffff;
		default:        return 32'h0;
	endcase
endfunction

function automatic logic [31:0] merge(input logic [31:0] old, wdata, mask);
	return (old & ~mask) | (wdata & mask);
endfunction

// Pending mtc0 as seen by the instruction committing in the same cycle
task automatic overlay(inout logic [31:0] st, ca, ep, ee,
		input logic we, input logic [4:0] addr, input logic [31:0] wdata);
	if (we) begin
		case (addr)
			`CP0_STATUS:    st = merge(st, wdata, mask_of(addr));
			`CP0_CAUSE:     ca = merge(ca, wdata, mask_of(addr));
			`CP0_EPC:       ep = merge(ep, wdata, mask_of(addr));
			`CP0_ERROR_EPC: ee = merge(ee, wdata, mask_of(addr));
			default: ;
		endcase
	end
endtask

// Flag bits are numbered in priority order
function automatic logic [4:0] code_of(input int idx, input logic mwe);
	case (idx)
		0:       return `EXCCODE_ADEL;
		1, 2:    return `EXCCODE_TLBL;
		3:       return `EXCCODE_SYS;
		4:       return `EXCCODE_BP;
		5:       return `EXCCODE_OV;
		6:       return `EXCCODE_TR;
		8:       return `EXCCODE_CPU;
		9:       return `EXCCODE_RI;
		10, 11:  return mwe ? `EXCCODE_ADES : `EXCCODE_ADEL;
		12, 13:  return mwe ? `EXCCODE_TLBS : `EXCCODE_TLBL;
		14:      return `EXCCODE_MOD;
		default: return 5'd0;
	endcase
endfunction

function automatic void resolve(input logic [31:0] st, ca, ep, ee,
		input logic [14:0] fa, fb, input logic [31:0] pca, pcb,
		input logic dsa, dsb, user, mwe,
		output logic flush, alpha, eret, ds, output logic [4:0] code,
		output logic [31:0] cur_pc, jump);
	logic [14:0] f;
	logic irq;
	logic hit;
	logic [31:0] ofs;
	int i;
	f = fa | fb;
	f[`EXC_PRIV_INST] = f[`EXC_PRIV_INST] & user;
	irq = st[`ST_IE] && !st[`ST_EXL] && !st[`ST_ERL] && ((ca[15:8] & st[15:8]) != 8'h0);
	flush = irq || (f != 15'h0);
	{alpha, eret, ds, code, cur_pc, jump} = '0;
	hit = irq;
	alpha = irq;
	for (i = 0; i < 15; i++) begin
		if (!hit && f[i]) begin
			hit = 1'b1;
			code = code_of(i, mwe);
			alpha = fa[i] | ((i == 10) & fa[11]);
			eret = (i == 7) & fa[7];
		end
	end
	if (!flush)
		return;
	ds = alpha ? dsa : dsb;
	cur_pc = alpha ? pca : pcb;
	if (!st[`ST_EXL] && (code == `EXCCODE_TLBL || code == `EXCCODE_TLBS) && !irq && !eret)
		ofs = `VEC_OFS_TLB;
	else if (!st[`ST_EXL] && irq && ca[`CA_IV])
		ofs = `VEC_OFS_IV;
	else
		ofs = `VEC_OFS_GEN;
	if (eret)
		jump = st[`ST_ERL] ? ee : ep;
	else
		jump = (st[`ST_BEV] ? `VEC_BASE_BEV : `VEC_BASE_NORM) + ofs;
endfunction

task automatic commit(inout logic [31:0] st, ca, ep, input logic eret,
		input logic [4:0] code, input logic [31:0] pc, input logic ds);
	if (eret) begin
		if (st[`ST_ERL])
			st[`ST_ERL] = 1'b0;
		else
			st[`ST_EXL] = 1'b0;
	end else begin
		if (!st[`ST_EXL]) begin
			ep = ds ? pc - 32'd4 : pc;
			ca[`CA_BD] = ds;
		end
		ca[`CA_EXCCODE] = code;
		st[`ST_EXL] = 1'b1;
	end
endtask

`endif

/* testbench/except_tb.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module except_tb;

	`include "except_model.svh"

	// Reset, then the five tests in order
	localparam int TEST_CYCLES = 10 + 30 + 300 + 8 * 13 + 22 + 14;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 200;

	logic clk, arst_n, wb_cyc, wb_stb, wb_we, wb_ack, wbk_cp0_we;
	logic [4:0] wb_adr, wbk_cp0_addr, exc_code;
	logic [31:0] wb_dat_i, wb_dat_o, wbk_cp0_wdata, pc_a, pc_b, exc_cur_pc, exc_jump_pc;
	logic [3:0] wb_sel;
	logic [5:0] hw_int;
	logic ds_a, ds_b, is_user_mode, mem_we;
	logic [14:0] flags_a, flags_b;
	logic exc_flush, exc_alpha_taken, exc_eret, exc_delayslot;
	logic [31:0] sh_st, sh_ca, sh_ep, sh_ee, rng, rd;
	logic check_en;
	int errors, checks, cycles, base, lat, i, b;

	except_subsys except_subsys_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] reg_of(input logic [4:0] addr);
		case (addr)
			`CP0_STATUS:    return sh_st;
			`CP0_CAUSE:     return sh_ca;
			`CP0_EPC:       return sh_ep;
			`CP0_ERROR_EPC: return sh_ee;
			default:        return 32'h0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("Error %s expected 0x%h got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	// Shadow CP0 follows the same edge as the DUT registers
	always @(posedge clk or negedge arst_n) begin : shadow_step
		logic f, al, er, ds;
		logic [4:0] c;
		logic [31:0] cp, jp;
		if (!arst_n) begin
			sh_st = `STATUS_RST;
			{sh_ca, sh_ep, sh_ee} = '0;
		end else begin
			overlay(sh_st, sh_ca, sh_ep, sh_ee, wbk_cp0_we, wbk_cp0_addr, wbk_cp0_wdata);
			resolve(sh_st, sh_ca, sh_ep, sh_ee, flags_a, flags_b, pc_a, pc_b, ds_a, ds_b,
				is_user_mode, mem_we, f, al, er, ds, c, cp, jp);
			if (f)
				commit(sh_st, sh_ca, sh_ep, er, c, cp, ds);
			sh_ca[`CA_IP_HW] = hw_int;
		end
	end

	initial begin : compare
		logic f, al, er, ds;
		logic [4:0] c;
		logic [31:0] st, ca, ep, ee, cp, jp;
		forever begin
			@(posedge clk);
			#90;
			if (check_en) begin
				{st, ca, ep, ee} = {sh_st, sh_ca, sh_ep, sh_ee};
				overlay(st, ca, ep, ee, wbk_cp0_we, wbk_cp0_addr, wbk_cp0_wdata);
				resolve(st, ca, ep, ee, flags_a, flags_b, pc_a, pc_b, ds_a, ds_b,
					is_user_mode, mem_we, f, al, er, ds, c, cp, jp);
				check("exc_flush", f, exc_flush);
				check("exc_alpha_taken", al, exc_alpha_taken);
				check("exc_eret", er, exc_eret);
				check("exc_delayslot", ds, exc_delayslot);
				check("exc_code", c, exc_code);
				check("exc_cur_pc", cp, exc_cur_pc);
				check("exc_jump_pc", jp, exc_jump_pc);
			end
		end
	end

	always @(posedge clk)
		cycles++;

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles, a test did not finish", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// Called 10 ns after an edge, returns 10 ns after the edge that drops the request
	task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdata, output int cnt);
		logic [31:0] wmask;
		wmask = mask_of(adr) & {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i, wb_sel} = {2'b11, we, adr, dat, sel};
		cnt = 0;
		do begin
			next_cycle();
			cnt++;
		end while (!wb_ack && cnt < 50);
		checks++;
		assert (wb_ack) else begin
			$display("Wishbone access to register %0d never acknowledged", adr);
			errors++;
		end
		rdata = wb_dat_o;
		if (we) begin
			case (adr)
				`CP0_STATUS:    sh_st = merge(sh_st, dat, wmask);
				`CP0_CAUSE:     sh_ca = merge(sh_ca, dat, wmask);
				`CP0_EPC:       sh_ep = merge(sh_ep, dat, wmask);
				`CP0_ERROR_EPC: sh_ee = merge(sh_ee, dat, wmask);
				default: ;
			endcase
		end
		next_cycle();
		{wb_cyc, wb_stb, wb_we} = 3'b000;
		checks++;
		assert (!wb_ack) else begin
			$display("Wishbone ack stayed high for more than one cycle");
			errors++;
		end
	endtask

	task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		int n;
		wb_access(1'b1, adr, dat, 4'hf, unused, n);
	endtask

	task automatic wb_read(input logic [4:0] adr);
		logic [31:0] data;
		int n;
		wb_access(1'b0, adr, 32'h0, 4'hf, data, n);
		check("wb_dat_o", reg_of(adr), data);
	endtask

	task automatic fire(input logic [14:0] fa, fb, input logic [31:0] pca, pcb,
			input logic dsa, dsb);
		{flags_a, flags_b, pc_a, pc_b, ds_a, ds_b} = {fa, fb, pca, pcb, dsa, dsb};
		next_cycle();
		{flags_a, flags_b} = '0;
	endtask

	task automatic finish_test(input int n, input string name);
		$display("Test %0d %s done, %0d errors", n, name, errors - base);
		base = errors;
	endtask

	initial begin
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i, wb_sel} = '0;
		{wbk_cp0_we, wbk_cp0_addr, wbk_cp0_wdata, hw_int} = '0;
		{pc_a, pc_b, ds_a, ds_b, flags_a, flags_b, is_user_mode, mem_we} = '0;
		{errors, checks, cycles, base} = '0;
		check_en = 1'b0;
		rng = 32'd68249;
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#10;
		arst_n = 1'b1;
		check_en = 1'b1;

		wb_read(`CP0_STATUS);
		wb_read(`CP0_CAUSE);
		wb_read(`CP0_EPC);
		wb_read(`CP0_ERROR_EPC);
		wb_read(5'd3);
		wb_access(1'b1, `CP0_STATUS, 32'hffff_ffff, 4'b0001, rd, lat);
		wb_read(`CP0_STATUS);
		wb_access(1'b1, `CP0_CAUSE, 32'hffff_ffff, 4'b0011, rd, lat);
		wb_read(`CP0_CAUSE);
		wb_access(1'b1, `CP0_EPC, 32'h1234_5678, 4'b1010, rd, lat);
		wb_read(`CP0_EPC);
		wb_write(5'd3, 32'hdead_beef);
		wb_read(5'd3);
		wb_write(`CP0_STATUS, `STATUS_RST);
		wb_write(`CP0_CAUSE, 32'h0);
		finish_test(1, "reset and wishbone access");

		for (i = 0; i < 300; i++) begin
			rng = xorshift(rng);
			flags_a = (rng[0] ? 15'd1 << (rng[7:4] % 15) : 15'd0)
				| (rng[1] ? 15'd1 << (rng[11:8] % 15) : 15'd0);
			flags_b = (rng[2] ? 15'd1 << (rng[15:12] % 15) : 15'd0)
				| (rng[3] ? 15'd1 << (rng[19:16] % 15) : 15'd0);
			flags_b[`EXC_ERET] = 1'b0;
			{ds_a, ds_b, is_user_mode, mem_we} = rng[23:20];
			rng = xorshift(rng);
			pc_a = {rng[31:2], 2'b00};
			rng = xorshift(rng);
			pc_b = {rng[31:2], 2'b00};
			next_cycle();
		end
		{flags_a, flags_b, ds_a, ds_b, is_user_mode, mem_we} = '0;
		finish_test(2, "priority and pipe select");

		for (b = 0; b < 8; b++) begin
			rd = {9'h0, b[2], 6'h0, 8'hff, 6'h0, b[1], 1'b1};
			wb_write(`CP0_STATUS, rd);
			wb_write(`CP0_CAUSE, {8'h0, b[0], 23'h0});
			fire(15'd1 << `EXC_IADDR_MISS, 15'h0, 32'h8000_0100, 32'h8000_0104, 1'b0, 1'b0);
			wb_write(`CP0_STATUS, rd);
			fire(15'h0, 15'd1 << `EXC_SYSCALL, 32'h8000_0200, 32'h8000_0204, 1'b0, 1'b0);
			wb_write(`CP0_STATUS, rd);
			hw_int = 6'b000001;
			next_cycle();
			hw_int = 6'b000000;
			repeat (2) next_cycle();
		end
		finish_test(3, "vector address");

		wb_write(`CP0_STATUS, 32'h0);
		fire(15'h0, 15'd1 << `EXC_SYSCALL, 32'h8000_1000, 32'h8000_1004, 1'b0, 1'b1);
		wb_read(`CP0_EPC);
		wb_read(`CP0_CAUSE);
		wb_read(`CP0_STATUS);
		fire(15'd1 << `EXC_SYSCALL, 15'h0, 32'h8000_2000, 32'h8000_2004, 1'b0, 1'b0);
		wb_read(`CP0_EPC);
		fire(15'd1 << `EXC_ERET, 15'h0, 32'h8000_3000, 32'h8000_3004, 1'b0, 1'b0);
		wb_read(`CP0_STATUS);
		wb_write(`CP0_ERROR_EPC, 32'hbfc0_1234);
		wb_write(`CP0_STATUS, 32'h0000_0006);
		fire(15'd1 << `EXC_ERET, 15'h0, 32'h8000_3000, 32'h8000_3004, 1'b0, 1'b0);
		wb_read(`CP0_STATUS);
		finish_test(4, "commit and eret");

		wb_write(`CP0_STATUS, 32'h0000_ff01);
		hw_int = 6'b000010;
		next_cycle();
		hw_int = 6'b000000;
		checks++;
		assert (exc_flush && exc_code === `EXCCODE_INT) else begin
			$display("Interrupt with matching mask was not raised");
			errors++;
		end
		next_cycle();
		wb_write(`CP0_STATUS, 32'h0000_ff01);
		hw_int = 6'b000010;
		next_cycle();
		fork
			begin
				{wbk_cp0_we, wbk_cp0_addr, wbk_cp0_wdata} = {1'b1, `CP0_STATUS, 32'h0000_ff00};
				next_cycle();
				wbk_cp0_we = 1'b0;
			end
			wb_access(1'b1, `CP0_EPC, 32'ha000_0040, 4'hf, rd, lat);
		join
		checks++;
		assert (lat == 2) else begin
			$display("Wishbone write during writeback took %0d cycles instead of 2", lat);
			errors++;
		end
		hw_int = 6'b000000;
		wb_read(`CP0_EPC);
		wb_read(`CP0_STATUS);
		finish_test(5, "interrupt and writeback bypass");

		$display("Checks passed %0d, failed %0d", checks - errors, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
